/* common/vp_config.svh */
// Build constants for the Videopac host block
// Clock divider ratios, memory address widths, cartridge size
// thresholds and download index values, shared by the RTL and testbench
`ifndef VP_CONFIG_SVH
`define VP_CONFIG_SVH

// System cycles per CPU enable
`define VP_CPU_DIV_NTSC 8
`define VP_CPU_DIV_PAL 12
// System cycles per VDC enable
`define VP_VDC_DIV_NTSC 6
`define VP_VDC_DIV_PAL 10

`define VP_LOAD_ADDR_W 14 // Cartridge image, up to 16K
`define VP_FONT_ADDR_W 9

// Byte counts that select the banking mode
`define VP_CART_4K 4096
`define VP_CART_8K 8192
`define VP_CART_16K 16384

`define VP_IDX_XROM 2
`define VP_IDX_FONT 3

`endif

/* common/vp_pkg.sv */
// Shared types of the Videopac host block
// Import inside a module body, or use scoped names in port lists
package vp_pkg;

	// Cartridge banking mode, chosen after a download
	typedef enum logic [2:0] {
		CART_2K,
		CART_4K,
		CART_8K,
		CART_16K,
		CART_XROM
	} cart_kind_t;

	// 24-bit display colour
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb24_t;

	// ASCII-style code handed to the console keyboard matrix
	typedef logic [7:0] key_code_t;

endpackage

/* hdl/vp_ctrl.sv */
// Machine control for the Videopac host block
// Holds the console in core reset, makes the CPU and VDC clock enables,
// tracks cartridge downloads and steers download writes to the memories
`timescale 1ns/1ps
`include "vp_config.svh"

module vp_ctrl (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                pal_i,
	input  logic                reset_button_i,
	input  logic                ioctl_download_i,
	input  logic                ioctl_wr_i,
	input  logic [7:0]          ioctl_index_i,
	output logic                core_reset_o,
	output logic                clk_cpu_en_o,
	output logic                clk_vdc_en_o,
	output logic                cart_we_o,
	output logic                font_we_o,
	output vp_pkg::cart_kind_t  cart_kind_o
);
	import vp_pkg::*;

	logic                      old_pal_q;
	logic                      old_download_q;
	logic                      core_rst_d;
	logic [3:0]                cpu_ctr_q;
	logic [3:0]                vdc_ctr_q;
	logic [3:0]                cpu_last;
	logic [3:0]                vdc_last;
	logic [`VP_LOAD_ADDR_W:0]  cart_size_q; // One bit wider to hold 16K
	logic                      xrom_q;
	logic                      cart_idx;

	assign core_rst_d = reset_button_i | ioctl_download_i | (pal_i != old_pal_q);
	assign cpu_last = pal_i ? 4'(`VP_CPU_DIV_PAL - 1) : 4'(`VP_CPU_DIV_NTSC - 1);
	assign vdc_last = pal_i ? 4'(`VP_VDC_DIV_PAL - 1) : 4'(`VP_VDC_DIV_NTSC - 1);

	//////////////////////////////
	// Core reset and clock enables

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_pal_q    <= 1'b0;
			core_reset_o <= 1'b1;
			cpu_ctr_q    <= '0;
			vdc_ctr_q    <= '0;
			clk_cpu_en_o <= 1'b0;
			clk_vdc_en_o <= 1'b0;
		end else begin
			old_pal_q    <= pal_i;
			core_reset_o <= core_rst_d;
			if (core_rst_d) begin // Dividers restart with the core
				cpu_ctr_q    <= '0;
				vdc_ctr_q    <= '0;
				clk_cpu_en_o <= 1'b0;
				clk_vdc_en_o <= 1'b0;
			end else begin
				clk_cpu_en_o <= (cpu_ctr_q >= cpu_last);
				cpu_ctr_q    <= (cpu_ctr_q >= cpu_last) ? '0 : cpu_ctr_q + 4'd1;
				clk_vdc_en_o <= (vdc_ctr_q >= vdc_last);
				vdc_ctr_q    <= (vdc_ctr_q >= vdc_last) ? '0 : vdc_ctr_q + 4'd1;
			end
		end
	end

	//////////////////////////////
	// Download tracking

	assign cart_idx  = (ioctl_index_i[1:0] < 2'd3);
	assign cart_we_o = ioctl_download_i & ioctl_wr_i & cart_idx;
	assign font_we_o = ioctl_download_i & ioctl_wr_i & ~cart_idx;

	// A font load leaves the cartridge size and mode alone
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_download_q <= 1'b0;
			cart_size_q    <= '0;
			xrom_q         <= 1'b0;
		end else begin
			old_download_q <= ioctl_download_i;
			if (ioctl_download_i && !old_download_q && cart_idx) begin
				cart_size_q <= (`VP_LOAD_ADDR_W + 1)'(cart_we_o);
				xrom_q      <= (ioctl_index_i == 8'(`VP_IDX_XROM));
			end else if (cart_we_o) begin
				cart_size_q <= cart_size_q + 1'b1;
			end
		end
	end

	always_comb begin
		if (xrom_q)
			cart_kind_o = CART_XROM;
		else if (cart_size_q == (`VP_LOAD_ADDR_W + 1)'(`VP_CART_4K))
			cart_kind_o = CART_4K;
		else if (cart_size_q == (`VP_LOAD_ADDR_W + 1)'(`VP_CART_8K))
			cart_kind_o = CART_8K;
		else if (cart_size_q == (`VP_LOAD_ADDR_W + 1)'(`VP_CART_16K))
			cart_kind_o = CART_16K;
		else
			cart_kind_o = CART_2K; // Any other size
	end

	// Each download byte lands in exactly one memory
	a_we_excl : assert property (@(posedge clk_sys) disable iff (reset)
		!(cart_we_o && font_we_o));

endmodule

/* cart/load_ram.sv */
// Byte memory filled over the download port
// One write port and one registered read port that only updates on re_i,
// so the read data holds between reads
`timescale 1ns/1ps

module load_ram #(
	parameter int ADDR_W = 14
) (
	input  logic              clk_sys,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] waddr_i,
	input  logic [7:0]        wdata_i,
	input  logic              re_i,
	input  logic [ADDR_W-1:0] raddr_i,
	output logic [7:0]        rdata_o
);

	logic [7:0] mem [2**ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// Read data held while re_i is low
	always_ff @(posedge clk_sys) begin
		if (re_i)
			rdata_o <= mem[raddr_i];
	end

endmodule

/* cart/cart_bank_map.sv */
// Cartridge memory with the console bank-switching rules
// Maps the 12-bit console address and the two bank lines onto the loaded
// image and returns the byte one cycle after a program-store read
`timescale 1ns/1ps
`include "vp_config.svh"

module cart_bank_map (
	input  logic                        clk_sys,
	input  vp_pkg::cart_kind_t          cart_kind_i,
	input  logic                        loading_i,
	input  logic [`VP_LOAD_ADDR_W-1:0]  load_addr_i,
	input  logic                        we_i,
	input  logic [7:0]                  wdata_i,
	input  logic [11:0]                 cart_addr_i,
	input  logic                        cart_bs0_i,
	input  logic                        cart_bs1_i,
	input  logic                        cart_rd_n_i,
	output logic [7:0]                  cart_data_o
);
	import vp_pkg::*;

	logic [`VP_LOAD_ADDR_W-1:0] rom_addr;
	logic [`VP_LOAD_ADDR_W-1:0] rd_addr;

	// A10 is skipped below 16K, the console mirrors it
	always_comb begin
		case (cart_kind_i)
			CART_4K:   rom_addr = {2'b00, cart_bs0_i, cart_addr_i[11], cart_addr_i[9:0]};
			CART_8K:   rom_addr = {1'b0, cart_bs1_i, cart_bs0_i,
				cart_addr_i[11], cart_addr_i[9:0]};
			CART_16K:  rom_addr = {cart_bs1_i, cart_bs0_i, cart_addr_i};
			CART_XROM: rom_addr = {2'b00, cart_addr_i};
			default:   rom_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
		endcase
	end

	assign rd_addr = loading_i ? load_addr_i : rom_addr;

	load_ram #(.ADDR_W(`VP_LOAD_ADDR_W)) cart_ram_i (
		.clk_sys (clk_sys),
		.we_i    (we_i),
		.waddr_i (load_addr_i),
		.wdata_i (wdata_i),
		.re_i    (~cart_rd_n_i), // Program store strobe
		.raddr_i (rd_addr),
		.rdata_o (cart_data_o)
	);

	// Console stays off the bus while the image loads
	a_no_rd_on_wr : assert property (@(posedge clk_sys) we_i |-> cart_rd_n_i);

endmodule

/* input/input_decoder.sv */
// Keyboard and joystick front end of the console
// Turns PS/2 scancode toggles and gamepad number buttons into one-cycle
// key events, and maps both joysticks onto active-low console lines
`timescale 1ns/1ps

module input_decoder (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic [10:0]        ps2_key_i, // [10] toggle, [9] pressed, [7:0] code
	input  logic [15:0]        joy0_i,
	input  logic [15:0]        joy1_i,
	input  logic               joy_swap_i,
	output logic               key_valid_o,
	output vp_pkg::key_code_t  key_code_o,
	output logic               key_released_o,
	output logic [1:0]         joy_up_n_o,
	output logic [1:0]         joy_down_n_o,
	output logic [1:0]         joy_left_n_o,
	output logic [1:0]         joy_right_n_o,
	output logic [1:0]         joy_action_n_o,
	output logic               joy_reset_n_o
);
	import vp_pkg::*;

	logic [15:0] joya;
	logic [15:0] joyb;
	logic [9:0]  joy_numpad;
	logic        ps2_event;
	logic        old_state_q;
	logic [9:0]  old_joy_q;
	logic        ps2_changed_q;
	logic        ps2_released_q;
	logic        joy_changed_q;
	logic        joy_released_q;
	key_code_t   ps2_ascii_q;
	key_code_t   joy_ascii_q;

	// Set 2 scancode to key code, extended flag not needed
	function automatic key_code_t scan_to_key(input logic [7:0] scan);
		case (scan)
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			8'h1F: return 8'h11; // Left GUI, yes
			8'h27: return 8'h12; // Right GUI, no
			8'h5A: return 8'd10; // Enter
			8'h66: return 8'd8;  // Backspace
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed number button wins
	function automatic key_code_t pad_to_key(input logic [9:0] pad);
		for (int i = 0; i < 9; i++) begin
			if (pad[i])
				return 8'("1" + i);
		end
		return pad[9] ? "0" : 8'h00;
	endfunction

	assign joya       = joy_swap_i ? joy1_i : joy0_i;
	assign joyb       = joy_swap_i ? joy0_i : joy1_i;
	assign joy_numpad = joy0_i[15:6] | joy1_i[15:6];
	assign ps2_event  = (old_state_q != ps2_key_i[10]);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_state_q    <= 1'b0;
			old_joy_q      <= '0;
			ps2_changed_q  <= 1'b0;
			ps2_released_q <= 1'b0;
			joy_changed_q  <= 1'b0;
			joy_released_q <= 1'b1;
			ps2_ascii_q    <= '0;
			joy_ascii_q    <= '0;
		end else begin
			old_state_q    <= ps2_key_i[10];
			old_joy_q      <= joy_numpad;
			ps2_changed_q  <= ps2_event;
			ps2_released_q <= ~ps2_key_i[9];
			joy_changed_q  <= |(joy_numpad ^ old_joy_q) & ~ps2_event;
			joy_released_q <= ~|joy_numpad;
			if (ps2_event)
				ps2_ascii_q <= scan_to_key(ps2_key_i[7:0]);
			else if (|joy_numpad)
				joy_ascii_q <= pad_to_key(joy_numpad); // Kept for the release event
		end
	end

	assign key_valid_o    = ps2_changed_q | joy_changed_q;
	assign key_code_o     = ps2_changed_q ? ps2_ascii_q : joy_ascii_q;
	assign key_released_o = ps2_released_q & joy_released_q;

	//////////////////////////////
	// Joystick lines, low when pressed, index 1 is joystick A

	assign joy_up_n_o     = {~joya[3], ~joyb[3]};
	assign joy_down_n_o   = {~joya[2], ~joyb[2]};
	assign joy_left_n_o   = {~joya[1], ~joyb[1]};
	assign joy_right_n_o  = {~joya[0], ~joyb[0]};
	assign joy_action_n_o = {~joya[4], ~joyb[4]};
	assign joy_reset_n_o  = ~(joy0_i[5] & joy1_i[5]); // Both players together

	// The console keyboard scan reads one event at a time
	a_key_pulse : assert property (@(posedge clk_sys) disable iff (reset)
		key_valid_o |=> !key_valid_o);

endmodule

/* hdl/palette_lut.sv */
// Colour lookup for the VDC output
// Indexes a calibrated NTSC or PAL palette by the {r,g,b,luma} code
`timescale 1ns/1ps

module palette_lut (
	input  logic            r_i,
	input  logic            g_i,
	input  logic            b_i,
	input  logic            luma_i,
	input  logic            pal_palette_i,
	output vp_pkg::rgb24_t  rgb_o
);
	import vp_pkg::*;

	localparam rgb24_t NTSC_LUT [16] = '{
		24'h000000, // Black
		24'h676767,
		24'h1a37be, // Blue
		24'h5c80f6,
		24'h006d07, // Green
		24'h56c469,
		24'h2aaabe, // Cyan
		24'h77e6eb,
		24'h790000, // Red
		24'hc75151,
		24'h94309f, // Violet
		24'hdc84e8,
		24'h77670b, // Yellow
		24'hc6b86a,
		24'hcecece, // White
		24'hffffff
	};

	// Flatter colours of the European machine
	localparam rgb24_t PAL_LUT [16] = '{
		24'h000000, 24'h494949,
		24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49,
		24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949,
		24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49,
		24'hb6b6b6, 24'hffffff
	};

	logic [3:0] idx;

	assign idx   = {r_i, g_i, b_i, luma_i}; // Odd entries are the bright ones
	assign rgb_o = pal_palette_i ? PAL_LUT[idx] : NTSC_LUT[idx];

endmodule

/* hdl/vp_host_top.sv */
// Host side of the Videopac console core
// Clock enables and core reset, cartridge and font download memories,
// keyboard and joystick decoding and the colour palette
`timescale 1ns/1ps
`include "vp_config.svh"

module vp_host_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        pal_i,
	input  logic                        reset_button_i,
	output logic                        core_reset_o,
	output logic                        clk_cpu_en_o,
	output logic                        clk_vdc_en_o,
	input  logic                        ioctl_download_i,
	input  logic                        ioctl_wr_i,
	input  logic [7:0]                  ioctl_index_i,
	input  logic [`VP_LOAD_ADDR_W-1:0]  ioctl_addr_i,
	input  logic [7:0]                  ioctl_dout_i,
	input  logic [11:0]                 cart_addr_i,
	input  logic                        cart_bs0_i,
	input  logic                        cart_bs1_i,
	input  logic                        cart_rd_n_i,
	output logic [7:0]                  cart_data_o,
	input  logic [`VP_FONT_ADDR_W-1:0]  char_addr_i,
	input  logic                        char_en_i,
	output logic [7:0]                  char_data_o,
	input  logic [10:0]                 ps2_key_i,
	input  logic [15:0]                 joy0_i,
	input  logic [15:0]                 joy1_i,
	input  logic                        joy_swap_i,
	output logic                        key_valid_o,
	output vp_pkg::key_code_t           key_code_o,
	output logic                        key_released_o,
	output logic [1:0]                  joy_up_n_o,
	output logic [1:0]                  joy_down_n_o,
	output logic [1:0]                  joy_left_n_o,
	output logic [1:0]                  joy_right_n_o,
	output logic [1:0]                  joy_action_n_o,
	output logic                        joy_reset_n_o,
	input  logic                        r_i,
	input  logic                        g_i,
	input  logic                        b_i,
	input  logic                        luma_i,
	input  logic                        pal_palette_i,
	output vp_pkg::rgb24_t              rgb_o
);
	import vp_pkg::*;

	logic       cart_we;
	logic       font_we;
	cart_kind_t cart_kind;

	vp_ctrl vp_ctrl_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.pal_i            (pal_i),
		.reset_button_i   (reset_button_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.core_reset_o     (core_reset_o),
		.clk_cpu_en_o     (clk_cpu_en_o),
		.clk_vdc_en_o     (clk_vdc_en_o),
		.cart_we_o        (cart_we),
		.font_we_o        (font_we),
		.cart_kind_o      (cart_kind)
	);

	cart_bank_map cart_bank_map_i (
		.clk_sys     (clk_sys),
		.cart_kind_i (cart_kind),
		.loading_i   (ioctl_download_i),
		.load_addr_i (ioctl_addr_i),
		.we_i        (cart_we),
		.wdata_i     (ioctl_dout_i),
		.cart_addr_i (cart_addr_i),
		.cart_bs0_i  (cart_bs0_i),
		.cart_bs1_i  (cart_bs1_i),
		.cart_rd_n_i (cart_rd_n_i),
		.cart_data_o (cart_data_o)
	);

	// Character ROM, replaced by a font download
	load_ram #(.ADDR_W(`VP_FONT_ADDR_W)) font_ram_i (
		.clk_sys (clk_sys),
		.we_i    (font_we),
		.waddr_i (ioctl_addr_i[`VP_FONT_ADDR_W-1:0]),
		.wdata_i (ioctl_dout_i),
		.re_i    (char_en_i),
		.raddr_i (char_addr_i),
		.rdata_o (char_data_o)
	);

	input_decoder input_decoder_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ps2_key_i      (ps2_key_i),
		.joy0_i         (joy0_i),
		.joy1_i         (joy1_i),
		.joy_swap_i     (joy_swap_i),
		.key_valid_o    (key_valid_o),
		.key_code_o     (key_code_o),
		.key_released_o (key_released_o),
		.joy_up_n_o     (joy_up_n_o),
		.joy_down_n_o   (joy_down_n_o),
		.joy_left_n_o   (joy_left_n_o),
		.joy_right_n_o  (joy_right_n_o),
		.joy_action_n_o (joy_action_n_o),
		.joy_reset_n_o  (joy_reset_n_o)
	);

	palette_lut palette_lut_i (
		.r_i           (r_i),
		.g_i           (g_i),
		.b_i           (b_i),
		.luma_i        (luma_i),
		.pal_palette_i (pal_palette_i),
		.rgb_o         (rgb_o)
	);

endmodule

/* tb/tb_clock.sv */
// Clock and reset source for the host block testbench
// 4 ns clock period, reset held high for the first two rising edges
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

/* tb/vp_host_tb.sv */
// Directed testbench for the Videopac host block
// Runs one task per feature: clock enables, cartridge banking, XROM and 2K
// loads, font loads, key events and palette with joystick lines.
// Inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps
`include "vp_config.svh"

module vp_host_tb;
	import vp_pkg::*;

	localparam int LOAD_W   = `VP_LOAD_ADDR_W;
	localparam int FONT_W   = `VP_FONT_ADDR_W;
	localparam int WAIT_MAX = 200;

	logic                clk_sys;
	logic                reset;
	logic                pal_i;
	logic                reset_button_i;
	logic                core_reset_o;
	logic                clk_cpu_en_o;
	logic                clk_vdc_en_o;
	logic                ioctl_download_i;
	logic                ioctl_wr_i;
	logic [7:0]          ioctl_index_i;
	logic [LOAD_W-1:0]   ioctl_addr_i;
	logic [7:0]          ioctl_dout_i;
	logic [11:0]         cart_addr_i;
	logic                cart_bs0_i;
	logic                cart_bs1_i;
	logic                cart_rd_n_i;
	logic [7:0]          cart_data_o;
	logic [FONT_W-1:0]   char_addr_i;
	logic                char_en_i;
	logic [7:0]          char_data_o;
	logic [10:0]         ps2_key_i;
	logic [15:0]         joy0_i;
	logic [15:0]         joy1_i;
	logic                joy_swap_i;
	logic                key_valid_o;
	key_code_t           key_code_o;
	logic                key_released_o;
	logic [1:0]          joy_up_n_o;
	logic [1:0]          joy_down_n_o;
	logic [1:0]          joy_left_n_o;
	logic [1:0]          joy_right_n_o;
	logic [1:0]          joy_action_n_o;
	logic                joy_reset_n_o;
	logic                r_i;
	logic                g_i;
	logic                b_i;
	logic                luma_i;
	logic                pal_palette_i;
	rgb24_t              rgb_o;

	logic [31:0] lfsr_q;
	logic [7:0]  cart_img [`VP_CART_16K]; // Model of the loaded cartridge
	logic [7:0]  font_img [2**FONT_W];
	string       test_name;
	int          errors;
	int          test_start_errors;
	int          tests_run;
	int          tests_failed;
	bit          aborted;

	tb_clock tb_clock_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	vp_host_top vp_host_top_i (.*);

	//////////////////////////////
	// Helpers

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r      = {r[30:0], fb};
		end
		return r;
	endfunction

	// Image address of a console read under each banking rule
	function automatic int image_addr(input cart_kind_t kind, input logic [11:0] a,
		input logic bs0, input logic bs1);
		int lo;
		int res;
		lo = int'(a[9:0]) + (a[11] ? 1024 : 0); // A10 skipped
		case (kind)
			CART_4K:  res = lo + (bs0 ? 2048 : 0);
			CART_8K:  res = lo + (bs0 ? 2048 : 0) + (bs1 ? 4096 : 0);
			CART_16K: res = int'(a) + (bs0 ? 4096 : 0) + (bs1 ? 8192 : 0);
			CART_XROM: res = int'(a);
			default:  res = lo;
		endcase
		return res;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("Fail %s: %s expected %0h, actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name         = name;
		test_start_errors = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_start_errors && !aborted) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", test_name, errors - test_start_errors);
		end
	endtask

	// Also flags any enable pulse seen while core reset is high
	task automatic wait_core_reset(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (core_reset_o !== level && n < WAIT_MAX) begin
			assert (!(core_reset_o && (clk_cpu_en_o || clk_vdc_en_o))) else begin
				$display("Clock enable pulsed during core reset in %s", test_name);
				errors++;
			end
			@(negedge clk_sys);
			n++;
		end
		if (core_reset_o !== level) begin
			$display("Timeout in %s, core reset never reached %b", test_name, level);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_key_valid();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!key_valid_o && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		if (!key_valid_o) begin
			$display("Timeout in %s, no key strobe arrived", test_name);
			errors++;
			aborted = 1'b1;
		end
	endtask

	//////////////////////////////
	// Stimulus tasks

	task automatic check_spacing(input int exp_cpu, input int exp_vdc);
		int last_cpu;
		int last_vdc;
		int n_cpu;
		int n_vdc;
		last_cpu = -1;
		last_vdc = -1;
		n_cpu = 0;
		n_vdc = 0;
		for (int cyc = 0; cyc < 50; cyc++) begin
			@(negedge clk_sys);
			if (clk_cpu_en_o) begin
				if (last_cpu >= 0)
					check_value("cpu enable spacing", exp_cpu, cyc - last_cpu);
				last_cpu = cyc;
				n_cpu++;
			end
			if (clk_vdc_en_o) begin
				if (last_vdc >= 0)
					check_value("vdc enable spacing", exp_vdc, cyc - last_vdc);
				last_vdc = cyc;
				n_vdc++;
			end
		end
		assert (n_cpu >= 2 && n_vdc >= 2) else begin
			$display("Too few clock enable pulses seen in %s", test_name);
			errors++;
		end
	endtask

	// Byte stream over the download port, the model follows the index rule
	task automatic load_image(input logic [7:0] index, input int nbytes);
		logic [7:0] data;
		@(posedge clk_sys);
		ioctl_download_i <= 1'b1;
		ioctl_index_i    <= index;
		for (int i = 0; i < nbytes; i++) begin
			@(posedge clk_sys);
			data = 8'(rand_bits(8));
			ioctl_addr_i <= LOAD_W'(i);
			ioctl_dout_i <= data;
			ioctl_wr_i   <= 1'b1;
			if (index[1:0] == 2'd3)
				font_img[i] = data;
			else
				cart_img[i] = data;
		end
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		@(negedge clk_sys);
		check_value("core reset during download", 1, core_reset_o);
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		wait_core_reset(1'b0);
	endtask

	task automatic read_cart(input cart_kind_t kind, input int nreads);
		logic [11:0] a;
		logic        bs0;
		logic        bs1;
		for (int i = 0; i < nreads; i++) begin
			a   = 12'(rand_bits(12));
			bs0 = 1'(rand_bits(1));
			bs1 = 1'(rand_bits(1));
			@(posedge clk_sys);
			cart_addr_i <= a;
			cart_bs0_i  <= bs0;
			cart_bs1_i  <= bs1;
			cart_rd_n_i <= 1'b0;
			@(posedge clk_sys);
			cart_rd_n_i <= 1'b1;
			@(negedge clk_sys);
			check_value("cart data", cart_img[image_addr(kind, a, bs0, bs1)], cart_data_o);
		end
	endtask

	task automatic read_font(input int nreads);
		logic [FONT_W-1:0] ca;
		for (int i = 0; i < nreads; i++) begin
			ca = FONT_W'(rand_bits(FONT_W));
			@(posedge clk_sys);
			char_addr_i <= ca;
			char_en_i   <= 1'b1;
			@(posedge clk_sys);
			char_en_i <= 1'b0;
			@(negedge clk_sys);
			check_value("char data", font_img[ca], char_data_o);
		end
	endtask

	task automatic expect_key(input logic [7:0] exp_code, input logic exp_rel);
		wait_key_valid();
		if (!aborted) begin
			check_value("key code", exp_code, key_code_o);
			check_value("key released", exp_rel, key_released_o);
			@(negedge clk_sys);
			check_value("key strobe length", 0, key_valid_o);
		end
	endtask

	task automatic scan_key(input logic [7:0] scan, input logic pressed,
		input logic [7:0] exp_code);
		@(posedge clk_sys);
		ps2_key_i <= {~ps2_key_i[10], pressed, 1'b0, scan}; // Toggle bit 10
		expect_key(exp_code, !pressed);
	endtask

	task automatic colour_case(input logic pal, input logic [3:0] idx, input rgb24_t exp);
		@(posedge clk_sys);
		{r_i, g_i, b_i, luma_i} <= idx;
		pal_palette_i           <= pal;
		@(negedge clk_sys);
		check_value("palette colour", exp, rgb_o);
	endtask

	task automatic joy_case(input logic [15:0] j0, input logic [15:0] j1, input logic sw);
		logic [15:0] ja;
		logic [15:0] jb;
		@(posedge clk_sys);
		joy0_i     <= j0;
		joy1_i     <= j1;
		joy_swap_i <= sw;
		@(negedge clk_sys);
		ja = sw ? j1 : j0; // Joystick A sits at index 1
		jb = sw ? j0 : j1;
		check_value("joy up", {~ja[3], ~jb[3]}, joy_up_n_o);
		check_value("joy down", {~ja[2], ~jb[2]}, joy_down_n_o);
		check_value("joy left", {~ja[1], ~jb[1]}, joy_left_n_o);
		check_value("joy right", {~ja[0], ~jb[0]}, joy_right_n_o);
		check_value("joy fire", {~ja[4], ~jb[4]}, joy_action_n_o);
		check_value("joy reset", !(j0[5] && j1[5]), joy_reset_n_o);
	endtask

	//////////////////////////////
	// Tests

	task automatic test_enable_timing();
		begin_test("enable_timing");
		wait_core_reset(1'b0);
		check_spacing(`VP_CPU_DIV_NTSC, `VP_VDC_DIV_NTSC);
		@(posedge clk_sys);
		pal_i <= 1'b1;
		wait_core_reset(1'b1);
		check_value("cpu enable in core reset", 0, clk_cpu_en_o);
		check_value("vdc enable in core reset", 0, clk_vdc_en_o);
		wait_core_reset(1'b0);
		check_spacing(`VP_CPU_DIV_PAL, `VP_VDC_DIV_PAL);
		finish_test();
	endtask

	task automatic test_cart_banking();
		begin_test("cart_banking");
		load_image(8'd0, `VP_CART_4K);
		read_cart(CART_4K, 200);
		load_image(8'd0, `VP_CART_8K);
		read_cart(CART_8K, 200);
		load_image(8'd0, `VP_CART_16K);
		read_cart(CART_16K, 200);
		finish_test();
	endtask

	task automatic test_xrom_and_2k();
		begin_test("xrom_and_2k");
		load_image(8'(`VP_IDX_XROM), 4096);
		read_cart(CART_XROM, 200);
		load_image(8'd0, 2048);
		read_cart(CART_2K, 200);
		finish_test();
	endtask

	task automatic test_font_load();
		begin_test("font_load");
		load_image(8'(`VP_IDX_FONT), 2**FONT_W);
		read_font(100);
		read_cart(CART_2K, 100); // Cartridge untouched by the font
		finish_test();
	endtask

	task automatic test_key_events();
		begin_test("key_events");
		scan_key(8'h1C, 1'b1, "a");
		scan_key(8'h2E, 1'b0, "5");
		scan_key(8'h5A, 1'b1, 8'd10); // Enter
		scan_key(8'h76, 1'b0, 8'h00); // Unmapped
		// Buttons 2 and 6 sit on bits 8 and 12, lowest one wins
		@(posedge clk_sys);
		joy0_i <= 16'h1100;
		expect_key("3", 1'b0);
		@(posedge clk_sys);
		joy0_i <= 16'h0000;
		expect_key("3", 1'b1);
		finish_test();
	endtask

	task automatic test_palette_joystick();
		begin_test("palette_joystick");
		colour_case(1'b0, 4'd0, 24'h000000);
		colour_case(1'b0, 4'd1, 24'h676767);
		colour_case(1'b0, 4'd15, 24'hffffff);
		colour_case(1'b1, 4'd2, 24'h0000b6);
		colour_case(1'b1, 4'd9, 24'hff4949);
		joy_case(16'h0020, 16'h0000, 1'b0);
		joy_case(16'h0000, 16'h0020, 1'b1);
		joy_case(16'h0020, 16'h0020, 1'b0);
		for (int i = 0; i < 32; i++)
			joy_case(16'(rand_bits(6)), 16'(rand_bits(6)), 1'(rand_bits(1)));
		finish_test();
	endtask

	initial begin
		int n;
		pal_i            = 1'b0;
		reset_button_i   = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_index_i    = '0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = '0;
		cart_addr_i      = '0;
		cart_bs0_i       = 1'b0;
		cart_bs1_i       = 1'b0;
		cart_rd_n_i      = 1'b1;
		char_addr_i      = '0;
		char_en_i        = 1'b0;
		ps2_key_i        = '0;
		joy0_i           = '0;
		joy1_i           = '0;
		joy_swap_i       = 1'b0;
		{r_i, g_i, b_i, luma_i} = 4'd0;
		pal_palette_i    = 1'b0;
		lfsr_q           = 32'hdb9b4883;
		errors           = 0;
		tests_run        = 0;
		tests_failed     = 0;
		aborted          = 1'b0;
		n = 0;
		while (reset && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (reset) begin
			$display("Reset was never released");
			errors++;
			aborted = 1'b1;
		end
		if (!aborted) test_enable_timing();
		if (!aborted) test_cart_banking();
		if (!aborted) test_xrom_and_2k();
		if (!aborted) test_font_load();
		if (!aborted) test_key_events();
		if (!aborted) test_palette_joystick();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !aborted)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+common
common/vp_pkg.sv
hdl/vp_ctrl.sv
cart/load_ram.sv
cart/cart_bank_map.sv
input/input_decoder.sv
hdl/palette_lut.sv
hdl/vp_host_top.sv
tb/tb_clock.sv
tb/vp_host_tb.sv

/* Makefile */
# Verilator build and run of the host block testbench
TOP = vp_host_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
